//--- test/soc_stimulus.txt
# op address data expected, all hex; data is a count for M and D
# W write, R read, L leds_o, P/H prng lo/hi, I wait irq, C irq level, M random ram, D idle
L 00000000 00 00
R FFFFFFF0 00 00
W FFFFFFF0 A5 00
L 00000000 00 A5
R FFFFFFF0 00 A5
W FFFFFFF7 3C 00
R FFFFFFFA 00 3C
L 00000000 00 3C
M 00000000 10 00
W 00002040 5A 00
R 00000040 00 5A
W 0001E07F C3 00
R 0000007F 00 C3
R FFFFF100 00 00
R FFFFFC10 00 00
P 00000000 00 00
W FFFFFE00 34 00
W FFFFFE01 12 00
P 00000000 00 00
P 00000000 00 00
H 00000000 00 00
H 00000000 00 00
P 00000000 00 00
P 00000000 00 00
W FFFFFD00 03 00
W FFFFFD01 00 00
W FFFFFD02 03 00
I 00000000 00 00
C 00000000 00 01
R FFFFFD03 00 01
W FFFFFD03 01 00
C 00000000 00 00
W FFFFFD02 01 00
D 00000000 80 00
C 00000000 00 00
R FFFFFD03 00 01
W FFFFFD02 00 00

//--- vlog.f
hw/soc_pkg.sv
hw/bus_decoder.sv
hw/ram_wb8.sv
hw/leds_wb8.sv
hw/timer_wb8.sv
hw/prng_wb8.sv
hw/soc_top.sv
test/tb_soc.sv

//--- Makefile
# Verilator build and run of the soc testbench

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_soc -f vlog.f -o sim_soc

run: compile
	@out="$$(./obj_dir/sim_soc)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- test/tb_soc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc import soc_pkg::*; ();

    localparam int RAM_ADDRBITS = 13;
    localparam int TICK_DIV     = 16;
    // largest timer reload in the stimulus
    localparam int MAX_RELOAD   = 3;
    localparam int IRQ_WAIT     = 64 * TICK_DIV * MAX_RELOAD;
    localparam string STIM_FILE = "test/soc_stimulus.txt";

    logic     clk;
    logic     rst_n_i;
    logic     bus_stb_i;
    logic     bus_we_i;
    bus_adr_u bus_adr_i;
    byte_t    bus_dat_i;
    byte_t    bus_dat_o;
    logic     bus_ack_o;
    byte_t    leds_o;
    logic     timer_irq_o;

    int          errors;
    int          passed;
    int          failed;
    logic [31:0] rng;
    logic [15:0] prng_model;

    soc_top #(
        .RAM_ADDRBITS (RAM_ADDRBITS),
        .TICK_DIV     (TICK_DIV)
    ) u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .bus_dat_i   (bus_dat_i),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            val = {val[30:0], rng[0]};
        end
    endtask

    // right shift, mask B400 when the dropped bit is 1
    function automatic logic [15:0] prng_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t expv);
        if (got !== expv) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, expv);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expv);
        if (got !== expv) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, expv);
            errors++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr, input byte_t wdat,
                              output byte_t rdat);
        int   late;
        logic acked;
        @(negedge clk);
        if (bus_ack_o !== 1'b0) begin
            $display("acknowledge seen before strobe at address %h", adr);
            errors++;
        end
        bus_stb_i = 1'b1;
        bus_we_i  = we;
        bus_adr_i = adr;
        bus_dat_i = wdat;
        @(negedge clk);
        acked     = bus_ack_o;
        rdat      = bus_dat_o;
        bus_stb_i = 1'b0;
        late      = 0;
        while (acked !== 1'b1 && late < 8) begin
            @(negedge clk);
            acked = bus_ack_o;
            rdat  = bus_dat_o;
            late++;
        end
        if (late != 0) begin
            $display("no acknowledge one cycle after strobe at address %h", adr);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input byte_t wdat);
        byte_t unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output byte_t rdat);
        bus_access(1'b0, adr, 8'h00, rdat);
    endtask

    task automatic ram_random(input int count);
        logic [31:0] ofs;
        logic [31:0] val;
        byte_t       rd;
        for (int i = 0; i < count; i++) begin
            rand_bits(RAM_ADDRBITS, ofs);
            rand_bits(8, val);
            bus_write(ofs, val[7:0]);
            bus_read(ofs, rd);
            check_byte("bus_dat_o", rd, val[7:0]);
            // same cell one RAM size higher
            bus_read(ofs + (32'd1 << RAM_ADDRBITS), rd);
            check_byte("bus_dat_o", rd, val[7:0]);
        end
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (timer_irq_o !== 1'b1 && n < IRQ_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq_o !== 1'b1) begin
            $display("timer interrupt did not rise within %0d cycles", IRQ_WAIT);
            errors++;
        end
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] adr, input byte_t dat,
                          input byte_t expv);
        byte_t rd;
        case (op)
            "W": begin
                bus_write(adr, dat);
                // seed writes load the model too
                if (adr == 32'hFFFF_FE00) begin
                    prng_model[7:0] = dat;
                end
                if (adr == 32'hFFFF_FE01) begin
                    prng_model[15:8] = dat;
                end
            end
            "R": begin
                bus_read(adr, rd);
                check_byte("bus_dat_o", rd, expv);
            end
            "P": begin
                bus_read(32'hFFFF_FE00, rd);
                check_byte("bus_dat_o", rd, prng_model[7:0]);
                prng_model = prng_next(prng_model);
            end
            "H": begin
                bus_read(32'hFFFF_FE01, rd);
                check_byte("bus_dat_o", rd, prng_model[15:8]);
            end
            "L": check_byte("leds_o", leds_o, expv);
            "C": check_bit("timer_irq_o", timer_irq_o, expv[0]);
            "I": wait_irq();
            "M": ram_random(int'(dat));
            "D": repeat (dat) @(negedge clk);
            default: begin
                $display("unknown stimulus op %c", op);
                errors++;
            end
        endcase
    endtask

    initial begin
        int              fd;
        int              code;
        int              line_no;
        int              errs_before;
        logic [8*8-1:0]  tok;
        logic [8*96-1:0] rest;
        logic [31:0]     adr;
        logic [31:0]     dat;
        logic [31:0]     expv;
        rst_n_i    = 1'b0;
        bus_stb_i  = 1'b0;
        bus_we_i   = 1'b0;
        bus_adr_i  = '0;
        bus_dat_i  = '0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        line_no    = 0;
        rng        = 32'h7249_e004;
        prng_model = 16'hACE1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", STIM_FILE);
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[7:0] == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    line_no++;
                    errs_before = errors;
                    code = $fscanf(fd, "%h %h %h", adr, dat, expv);
                    if (code != 3) begin
                        $display("stimulus entry %0d is missing fields", line_no);
                        errors++;
                    end else begin
                        run_op(tok[7:0], adr, dat[7:0], expv[7:0]);
                    end
                    if (errors == errs_before) begin
                        passed++;
                        $display("test %0d: %c %h %h ok", line_no, tok[7:0], adr, dat[7:0]);
                    end else begin
                        failed++;
                        $display("test %0d: %c %h %h FAILED", line_no, tok[7:0], adr, dat[7:0]);
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run length from the stimulus size and the slowest timer expiry
    initial begin
        int              fd;
        int              lines;
        int              limit;
        logic [8*96-1:0] text;
        lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
        limit = 8 + lines * 200 + IRQ_WAIT;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top import soc_pkg::*; #(
    parameter int RAM_ADDRBITS = 13,
    parameter int TICK_DIV     = 16
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     bus_stb_i,
    input  logic     bus_we_i,
    input  bus_adr_u bus_adr_i,
    input  byte_t    bus_dat_i,
    output byte_t    bus_dat_o,
    output logic     bus_ack_o,
    output byte_t    leds_o,
    output logic     timer_irq_o
);

    logic  ram_stb;
    logic  leds_stb;
    logic  timer_stb;
    logic  prng_stb;
    byte_t ram_dat;
    byte_t leds_dat;
    byte_t timer_dat;
    byte_t prng_dat;
    logic  ram_ack;
    logic  leds_ack;
    logic  timer_ack;
    logic  prng_ack;

    bus_decoder u_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .ram_stb_o   (ram_stb),
        .leds_stb_o  (leds_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .ram_dat_i   (ram_dat),
        .ram_ack_i   (ram_ack),
        .leds_dat_i  (leds_dat),
        .leds_ack_i  (leds_ack),
        .timer_dat_i (timer_dat),
        .timer_ack_i (timer_ack),
        .prng_dat_i  (prng_dat),
        .prng_ack_i  (prng_ack),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o)
    );

    ram_wb8 #(
        .RAM_ADDRBITS (RAM_ADDRBITS)
    ) u_ram (
        .clk   (clk),
        .stb_i (ram_stb),
        .we_i  (bus_we_i),
        .adr_i (bus_adr_i),
        .dat_i (bus_dat_i),
        .dat_o (ram_dat),
        .ack_o (ram_ack)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (leds_stb),
        .we_i    (bus_we_i),
        .dat_i   (bus_dat_i),
        .dat_o   (leds_dat),
        .ack_o   (leds_ack),
        .leds_o  (leds_o)
    );

    timer_wb8 #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (timer_stb),
        .we_i    (bus_we_i),
        .adr_i   (bus_adr_i),
        .dat_i   (bus_dat_i),
        .dat_o   (timer_dat),
        .ack_o   (timer_ack),
        .irq_o   (timer_irq_o)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (prng_stb),
        .we_i    (bus_we_i),
        .adr_i   (bus_adr_i),
        .dat_i   (bus_dat_i),
        .dat_o   (prng_dat),
        .ack_o   (prng_ack)
    );

endmodule

`default_nettype wire

//--- hw/prng_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module prng_wb8 import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  bus_adr_u adr_i,
    input  byte_t    dat_i,
    output byte_t    dat_o,
    output logic     ack_o
);

    logic [15:0] state_q;

    // galois lfsr, shifting right
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ PRNG_MASK;
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= PRNG_SEED;
            ack_o   <= 1'b0;
        end else begin
            ack_o <= stb_i;
            if (stb_i && we_i) begin
                if (adr_i.io.ofs == PRNG_LO) begin
                    state_q[7:0] <= dat_i;
                end else if (adr_i.io.ofs == PRNG_HI) begin
                    state_q[15:8] <= dat_i;
                end
            end else if (stb_i && adr_i.io.ofs == PRNG_LO) begin
                // step only after the low byte was taken
                state_q <= lfsr_step(state_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i && !we_i) begin
            case (adr_i.io.ofs)
                PRNG_LO: dat_o <= state_q[7:0];
                PRNG_HI: dat_o <= state_q[15:8];
                default: dat_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/timer_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module timer_wb8 import soc_pkg::*; #(
    parameter int TICK_DIV = 16
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  bus_adr_u adr_i,
    input  byte_t    dat_i,
    output byte_t    dat_o,
    output logic     ack_o,
    output logic     irq_o
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [15:0]      reload_q;
    logic [15:0]      count_q;
    logic [PRE_W-1:0] pre_q;
    logic             en_q;
    logic             ie_q;
    logic             expired_q;
    logic             tick;
    logic             wr;
    logic             last;

    assign wr   = stb_i & we_i;
    assign tick = en_q && (pre_q == PRE_W'(TICK_DIV - 1));
    assign last = (count_q <= 16'd1);

    always_ff @(posedge clk) begin
        if (wr && adr_i.io.ofs == TMR_RELOAD_LO) begin
            reload_q[7:0] <= dat_i;
        end
        if (wr && adr_i.io.ofs == TMR_RELOAD_HI) begin
            reload_q[15:8] <= dat_i;
        end
    end

    // enabling restarts from reload
    always_ff @(posedge clk) begin
        if (wr && adr_i.io.ofs == TMR_CTRL && dat_i[0]) begin
            count_q <= reload_q;
        end else if (tick) begin
            count_q <= last ? reload_q : count_q - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_q      <= 1'b0;
            ie_q      <= 1'b0;
            expired_q <= 1'b0;
            pre_q     <= '0;
            ack_o     <= 1'b0;
        end else begin
            ack_o <= stb_i;
            if (tick) begin
                pre_q <= '0;
            end else if (en_q) begin
                pre_q <= pre_q + 1'b1;
            end
            // write 1 to clear, a new expiry wins
            if (wr && adr_i.io.ofs == TMR_STATUS && dat_i[0]) begin
                expired_q <= 1'b0;
            end
            if (tick && last) begin
                expired_q <= 1'b1;
            end
            if (wr && adr_i.io.ofs == TMR_CTRL) begin
                en_q  <= dat_i[0];
                ie_q  <= dat_i[1];
                pre_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i && !we_i) begin
            case (adr_i.io.ofs)
                TMR_RELOAD_LO: dat_o <= reload_q[7:0];
                TMR_RELOAD_HI: dat_o <= reload_q[15:8];
                TMR_CTRL:      dat_o <= {6'b0, ie_q, en_q};
                TMR_STATUS:    dat_o <= {7'b0, expired_q};
                default:       dat_o <= '0;
            endcase
        end
    end

    assign irq_o = expired_q & ie_q;

endmodule

`default_nettype wire

//--- hw/leds_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module leds_wb8 import soc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  byte_t dat_i,
    output byte_t dat_o,
    output logic  ack_o,
    output byte_t leds_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            leds_o <= '0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= stb_i;
            // new value shows up with the ack
            if (stb_i && we_i) begin
                leds_o <= dat_i;
            end
        end
    end

    // read back
    always_ff @(posedge clk) begin
        if (stb_i && !we_i) begin
            dat_o <= leds_o;
        end
    end

endmodule

`default_nettype wire

//--- hw/ram_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module ram_wb8 import soc_pkg::*; #(
    parameter int RAM_ADDRBITS = 13
) (
    input  logic     clk,
    input  logic     stb_i,
    input  logic     we_i,
    input  bus_adr_u adr_i,
    input  byte_t    dat_i,
    output byte_t    dat_o,
    output logic     ack_o
);

    byte_t mem [0:(2**RAM_ADDRBITS)-1];

    logic [RAM_ADDRBITS-1:0] idx;

    // upper address bits ignored, so the region aliases
    assign idx = adr_i.mem.ofs[RAM_ADDRBITS-1:0];

    always_ff @(posedge clk) begin
        if (stb_i) begin
            if (we_i) begin
                mem[idx] <= dat_i;
            end
            dat_o <= mem[idx];
        end
    end

    // never stalls
    always_ff @(posedge clk) begin
        ack_o <= stb_i;
    end

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module bus_decoder import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     bus_stb_i,
    input  logic     bus_we_i,
    input  bus_adr_u bus_adr_i,
    output logic     ram_stb_o,
    output logic     leds_stb_o,
    output logic     timer_stb_o,
    output logic     prng_stb_o,
    input  byte_t    ram_dat_i,
    input  logic     ram_ack_i,
    input  byte_t    leds_dat_i,
    input  logic     leds_ack_i,
    input  byte_t    timer_dat_i,
    input  logic     timer_ack_i,
    input  byte_t    prng_dat_i,
    input  logic     prng_ack_i,
    output byte_t    bus_dat_o,
    output logic     bus_ack_o
);

    logic is_io;
    logic sel_leds;
    logic sel_timer;
    logic sel_prng;
    logic sel_none;
    logic none_ack_q;

    always_comb begin
        is_io     = (bus_adr_i >= IO_BASE);
        sel_timer = is_io && (bus_adr_i.io.page == PAGE_TIMER);
        sel_prng  = is_io && (bus_adr_i.io.page == PAGE_PRNG);
        sel_leds  = is_io && (bus_adr_i.io.page == PAGE_LEDS)
                    && (bus_adr_i.io.ofs[7:4] == LEDS_OFS_HI);
        // reserved io, nobody answers
        sel_none  = is_io && !sel_timer && !sel_prng && !sel_leds;
    end

    assign ram_stb_o   = bus_stb_i & ~is_io;
    assign leds_stb_o  = bus_stb_i & sel_leds;
    assign timer_stb_o = bus_stb_i & sel_timer;
    assign prng_stb_o  = bus_stb_i & sel_prng;

    // local ack for unmapped io
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= bus_stb_i & sel_none;
        end
    end

    always_comb begin
        bus_dat_o = '0;
        bus_ack_o = none_ack_q;
        if (!is_io) begin
            bus_dat_o = ram_dat_i;
            bus_ack_o = ram_ack_i;
        end else if (sel_leds) begin
            bus_dat_o = leds_dat_i;
            bus_ack_o = leds_ack_i;
        end else if (sel_timer) begin
            bus_dat_o = timer_dat_i;
            bus_ack_o = timer_ack_i;
        end else if (sel_prng) begin
            bus_dat_o = prng_dat_i;
            bus_ack_o = prng_ack_i;
        end
        // no read data during writes
        if (bus_we_i) begin
            bus_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

    typedef logic [7:0] byte_t;

    // one bus address, seen as io page/offset or as memory offset
    typedef union packed {
        struct packed {
            logic [23:0] page;
            logic [7:0]  ofs;
        } io;
        struct packed {
            logic [18:0] hi;
            logic [12:0] ofs;
        } mem;
    } bus_adr_u;

    // first address of the reserved io area
    localparam logic [31:0] IO_BASE = 32'hFFFF_F000;

    localparam logic [23:0] PAGE_TIMER = 24'hFFFFFD;
    localparam logic [23:0] PAGE_PRNG  = 24'hFFFFFE;
    localparam logic [23:0] PAGE_LEDS  = 24'hFFFFFF;

    // leds occupy FFFFFFF0 to FFFFFFFF only
    localparam logic [3:0] LEDS_OFS_HI = 4'hF;

    localparam byte_t TMR_RELOAD_LO = 8'h00;
    localparam byte_t TMR_RELOAD_HI = 8'h01;
    localparam byte_t TMR_CTRL      = 8'h02;
    localparam byte_t TMR_STATUS    = 8'h03;

    localparam byte_t PRNG_LO = 8'h00;
    localparam byte_t PRNG_HI = 8'h01;

    localparam logic [15:0] PRNG_SEED = 16'hACE1;
    localparam logic [15:0] PRNG_MASK = 16'hB400;

endpackage

`default_nettype wire
